/* analyzer/analyzer_regs.sv */
`timescale 1ns/1ps

module analyzer_regs (
    input  logic                         clk,
    input  logic                         reset_i,
    input  capture_pkg::sample_t         probe_i,
    input  capture_pkg::capture_state_e  state_i,
    input  capture_pkg::sample_addr_t    read_ptr_i,
    input  capture_pkg::sample_addr_t    write_ptr_i,
    output logic                         trig_o,
    output capture_pkg::sample_addr_t    trigger_loc_o,
    output logic                         start_pulse_o,
    output logic                         stop_pulse_o,
    bus_if.sink                          up,
    bus_if.source                        down
);
    import bridge_pkg::*;
    import capture_pkg::*;

    trigger_op_e trig_op;
    sample_t trig_arg;
    sample_t probe_prev;
    logic start_bit;
    logic stop_bit;
    logic start_prev;
    logic stop_prev;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            trig_op <= DISABLE;
            trig_arg <= '0;
            trigger_loc_o <= '0;
            start_bit <= 1'b0;
            stop_bit <= 1'b0;
            start_prev <= 1'b0;
            stop_prev <= 1'b0;
            probe_prev <= '0;
            down.valid <= 1'b0;
        end else begin
            start_prev <= start_bit;
            stop_prev <= stop_bit;
            probe_prev <= probe_i;
            down.valid <= up.valid;
            if (up.valid && up.rw) begin
                case (up.addr)
                    REG_TRIG_OP: trig_op <= trigger_op_e'(up.data[3:0]);
                    REG_TRIG_ARG: trig_arg <= up.data[7:0];
                    REG_TRIG_LOC: trigger_loc_o <= up.data[5:0];
                    REG_START: start_bit <= up.data[0];
                    REG_STOP: stop_bit <= up.data[0];
                    default: ;
                endcase
            end
        end
    end

    // forward everything, answer reads of our own addresses
    always_ff @(posedge clk) begin
        down.addr <= up.addr;
        down.rw <= up.rw;
        down.data <= up.data;
        if (up.valid && !up.rw) begin
            case (up.addr)
                REG_STATE: down.data <= word_t'(state_i);
                REG_TRIG_OP: down.data <= word_t'(trig_op);
                REG_TRIG_ARG: down.data <= word_t'(trig_arg);
                REG_TRIG_LOC: down.data <= word_t'(trigger_loc_o);
                REG_START: down.data <= word_t'(start_bit);
                REG_STOP: down.data <= word_t'(stop_bit);
                REG_READ_PTR: down.data <= word_t'(read_ptr_i);
                REG_WRITE_PTR: down.data <= word_t'(write_ptr_i);
                default: ;
            endcase
        end
    end

    // only a 0 to 1 transition of the control bits acts
    assign start_pulse_o = start_bit && !start_prev;
    assign stop_pulse_o = stop_bit && !stop_prev;

    always_comb begin
        case (trig_op)
            RISING: trig_o = probe_i > probe_prev;
            FALLING: trig_o = probe_i < probe_prev;
            CHANGING: trig_o = probe_i != probe_prev;
            GT: trig_o = probe_i > trig_arg;
            LT: trig_o = probe_i < trig_arg;
            GEQ: trig_o = probe_i >= trig_arg;
            LEQ: trig_o = probe_i <= trig_arg;
            EQ: trig_o = probe_i == trig_arg;
            NEQ: trig_o = probe_i != trig_arg;
            default: trig_o = 1'b0;
        endcase
    end

endmodule

/* analyzer/capture_ctrl.sv */
`timescale 1ns/1ps

module capture_ctrl (
    input  logic                         clk,
    input  logic                         reset_i,
    input  capture_pkg::sample_t         probe_i,
    input  logic                         trig_i,
    input  capture_pkg::sample_addr_t    trigger_loc_i,
    input  logic                         start_pulse_i,
    input  logic                         stop_pulse_i,
    output capture_pkg::capture_state_e  state_o,
    output capture_pkg::sample_addr_t    read_ptr_o,
    output capture_pkg::sample_addr_t    write_ptr_o,
    bus_if.sink                          up,
    bus_if.source                        down
);
    import bridge_pkg::*;
    import capture_pkg::*;

    sample_t sample_mem [SAMPLE_DEPTH];
    logic mem_we;
    sample_t rd_sample;

    // first pipeline stage of the bus
    word_t s1_addr;
    word_t s1_data;
    logic s1_rw;
    logic s1_valid;
    logic s1_hit;

    // capturing stops writing once the buffer is full
    assign mem_we = (state_o == MOVE_TO_POSITION) || (state_o == IN_POSITION)
                    || (state_o == CAPTURING && write_ptr_o != read_ptr_o);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_o <= IDLE;
            read_ptr_o <= '0;
            write_ptr_o <= '0;
        end else begin
            case (state_o)
                IDLE: begin
                    read_ptr_o <= '0;
                    write_ptr_o <= '0;
                    if (start_pulse_i) begin
                        state_o <= MOVE_TO_POSITION;
                    end
                end
                MOVE_TO_POSITION: begin
                    write_ptr_o <= write_ptr_o + 1'b1;
                    if (write_ptr_o == trigger_loc_i) begin
                        state_o <= trig_i ? CAPTURING : IN_POSITION;
                    end
                end
                IN_POSITION: begin
                    // keep a fixed pre-trigger window sliding around the ring
                    write_ptr_o <= write_ptr_o + 1'b1;
                    read_ptr_o <= read_ptr_o + 1'b1;
                    if (trig_i) begin
                        state_o <= CAPTURING;
                    end
                end
                CAPTURING: begin
                    if (write_ptr_o == read_ptr_o) begin
                        state_o <= CAPTURED;
                    end else begin
                        write_ptr_o <= write_ptr_o + 1'b1;
                    end
                end
                default: ;
            endcase
            if (stop_pulse_i) begin
                state_o <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            sample_mem[write_ptr_o] <= probe_i;
        end
        rd_sample <= sample_mem[sample_addr_t'(up.addr - SAMPLE_BASE)];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            down.valid <= 1'b0;
        end else begin
            s1_valid <= up.valid;
            down.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= up.addr;
        s1_data <= up.data;
        s1_rw <= up.rw;
        s1_hit <= up.valid && !up.rw && up.addr >= SAMPLE_BASE
                  && up.addr < SAMPLE_BASE + SAMPLE_DEPTH;
        down.addr <= s1_addr;
        down.rw <= s1_rw;
        down.data <= s1_hit ? word_t'(rd_sample) : s1_data;
    end

endmodule

/* bridge/command_parser.sv */
`timescale 1ns/1ps

module command_parser (
    input  logic               clk,
    input  logic               reset_i,
    input  bridge_pkg::byte_t  data_i,
    input  logic               valid_i,
    bus_if.source              bus
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, WRITE} parser_state_e;

    parser_state_e state;
    logic [3:0] byte_cnt;
    logic [3:0] n_digits;
    logic [31:0] digits;
    logic [3:0] nibble;
    logic is_hex;
    logic is_term;
    logic at_term;

    // uppercase hex only
    always_comb begin
        is_hex = 1'b1;
        nibble = '0;
        if (data_i >= 8'h30 && data_i <= 8'h39) begin
            nibble = data_i[3:0];
        end else if (data_i >= 8'h41 && data_i <= 8'h46) begin
            nibble = data_i[3:0] + 4'd9;
        end else begin
            is_hex = 1'b0;
        end
    end

    assign is_term = (data_i == CHAR_CR) || (data_i == CHAR_LF);
    assign n_digits = (state == WRITE) ? 4'd8 : 4'd4;
    assign at_term = valid_i && (state != IDLE) && (byte_cnt == n_digits);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
            byte_cnt <= '0;
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= 1'b0;
            if (valid_i) begin
                if (state == IDLE) begin
                    byte_cnt <= '0;
                    if (data_i == CHAR_READ) begin
                        state <= READ;
                    end else if (data_i == CHAR_WRITE) begin
                        state <= WRITE;
                    end
                end else if (byte_cnt < n_digits) begin
                    byte_cnt <= byte_cnt + 4'd1;
                    if (!is_hex) begin
                        state <= IDLE;
                    end
                end else begin
                    // anything but CR or LF here drops the command
                    state <= IDLE;
                    bus.valid <= is_term;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && state != IDLE && byte_cnt < n_digits) begin
            digits <= {digits[27:0], nibble};
        end
        if (at_term) begin
            bus.rw <= (state == WRITE);
            bus.addr <= (state == WRITE) ? digits[31:16] : digits[15:0];
            bus.data <= (state == WRITE) ? digits[15:0] : '0;
        end
    end

endmodule

/* bridge/response_formatter.sv */
`timescale 1ns/1ps

module response_formatter (
    input  logic               clk,
    input  logic               reset_i,
    bus_if.sink                bus,
    output bridge_pkg::byte_t  tx_data_o,
    output logic               tx_start_o,
    input  logic               tx_done_i
);
    import bridge_pkg::*;

    logic busy;
    word_t value;
    // D, four digits, CR, LF
    logic [2:0] byte_idx;
    logic new_read;

    function automatic byte_t hex_char(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + byte_t'(n);
        end
        return 8'h37 + byte_t'(n);
    endfunction

    assign new_read = bus.valid && !bus.rw;
    assign tx_start_o = busy;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            byte_idx <= '0;
        end else if (!busy) begin
            byte_idx <= '0;
            busy <= new_read;
        end else if (tx_done_i) begin
            // transmitter took the current byte
            if (byte_idx == 3'd6) begin
                busy <= 1'b0;
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    // reads arriving mid-response are dropped
    always_ff @(posedge clk) begin
        if (!busy && new_read) begin
            value <= bus.data;
        end
    end

    always_comb begin
        case (byte_idx)
            3'd0: tx_data_o = CHAR_DATA;
            3'd1: tx_data_o = hex_char(value[15:12]);
            3'd2: tx_data_o = hex_char(value[11:8]);
            3'd3: tx_data_o = hex_char(value[7:4]);
            3'd4: tx_data_o = hex_char(value[3:0]);
            3'd5: tx_data_o = CHAR_CR;
            default: tx_data_o = CHAR_LF;
        endcase
    end

endmodule

/* common/bridge_pkg.sv */
package bridge_pkg;

    // one serial byte
    typedef logic [7:0] byte_t;

    // bus address or data word
    typedef logic [15:0] word_t;

    // clock cycles per serial bit
    localparam int CLKS_PER_BAUD = 16;

    // baud counters must hold one and a half bit times
    localparam int BAUD_CNT_W = $clog2(2 * CLKS_PER_BAUD);

    typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

    // command and response framing characters
    localparam byte_t CHAR_READ = 8'h52;
    localparam byte_t CHAR_WRITE = 8'h57;
    localparam byte_t CHAR_DATA = 8'h44;
    localparam byte_t CHAR_CR = 8'h0D;
    localparam byte_t CHAR_LF = 8'h0A;

endpackage

/* common/bus_if.sv */
`timescale 1ns/1ps

interface bus_if;
    import bridge_pkg::*;

    word_t addr;
    word_t data;
    // high for a write
    logic rw;
    // one-cycle strobe per transaction
    logic valid;

    modport source (output addr, output data, output rw, output valid);
    modport sink (input addr, input data, input rw, input valid);

endinterface

/* common/capture_pkg.sv */
package capture_pkg;

    // one probe sample
    typedef logic [7:0] sample_t;

    // index into the sample memory
    typedef logic [5:0] sample_addr_t;

    localparam int SAMPLE_DEPTH = 64;

    typedef enum logic [3:0] {
        IDLE = 4'd0,
        MOVE_TO_POSITION = 4'd1,
        IN_POSITION = 4'd2,
        CAPTURING = 4'd3,
        CAPTURED = 4'd4
    } capture_state_e;

    typedef enum logic [3:0] {
        DISABLE = 4'd0,
        RISING = 4'd1,
        FALLING = 4'd2,
        CHANGING = 4'd3,
        GT = 4'd4,
        LT = 4'd5,
        GEQ = 4'd6,
        LEQ = 4'd7,
        EQ = 4'd8,
        NEQ = 4'd9
    } trigger_op_e;

    // register map
    localparam logic [15:0] REG_STATE = 16'd0;
    localparam logic [15:0] REG_TRIG_OP = 16'd1;
    localparam logic [15:0] REG_TRIG_ARG = 16'd2;
    localparam logic [15:0] REG_TRIG_LOC = 16'd3;
    localparam logic [15:0] REG_START = 16'd4;
    localparam logic [15:0] REG_STOP = 16'd5;
    localparam logic [15:0] REG_READ_PTR = 16'd6;
    localparam logic [15:0] REG_WRITE_PTR = 16'd7;

    // samples sit at SAMPLE_BASE up to SAMPLE_BASE + SAMPLE_DEPTH - 1
    localparam logic [15:0] SAMPLE_BASE = 16'd16;

endpackage

/* logic/la_top.sv */
`timescale 1ns/1ps

module la_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  rx_i,
    output logic                  tx_o,
    input  capture_pkg::sample_t  probe_i
);
    import bridge_pkg::*;
    import capture_pkg::*;

    byte_t rx_data;
    logic rx_valid;
    byte_t tx_data;
    logic tx_start;
    logic tx_done;

    logic trig;
    sample_addr_t trigger_loc;
    logic start_pulse;
    logic stop_pulse;
    capture_state_e state;
    sample_addr_t read_ptr;
    sample_addr_t write_ptr;

    bus_if parser_bus ();
    bus_if regs_bus ();
    bus_if capture_bus ();

    uart_rx u_uart_rx (
        .clk     (clk),
        .reset_i (reset_i),
        .rx_i    (rx_i),
        .data_o  (rx_data),
        .valid_o (rx_valid)
    );

    command_parser u_command_parser (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (rx_data),
        .valid_i (rx_valid),
        .bus     (parser_bus.source)
    );

    analyzer_regs u_analyzer_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .probe_i       (probe_i),
        .state_i       (state),
        .read_ptr_i    (read_ptr),
        .write_ptr_i   (write_ptr),
        .trig_o        (trig),
        .trigger_loc_o (trigger_loc),
        .start_pulse_o (start_pulse),
        .stop_pulse_o  (stop_pulse),
        .up            (parser_bus.sink),
        .down          (regs_bus.source)
    );

    capture_ctrl u_capture_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .probe_i       (probe_i),
        .trig_i        (trig),
        .trigger_loc_i (trigger_loc),
        .start_pulse_i (start_pulse),
        .stop_pulse_i  (stop_pulse),
        .state_o       (state),
        .read_ptr_o    (read_ptr),
        .write_ptr_o   (write_ptr),
        .up            (regs_bus.sink),
        .down          (capture_bus.source)
    );

    response_formatter u_response_formatter (
        .clk        (clk),
        .reset_i    (reset_i),
        .bus        (capture_bus.sink),
        .tx_data_o  (tx_data),
        .tx_start_o (tx_start),
        .tx_done_i  (tx_done)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (tx_data),
        .start_i (tx_start),
        .done_o  (tx_done),
        .tx_o    (tx_o)
    );

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               rx_i,
    output bridge_pkg::byte_t  data_o,
    output logic               valid_o
);
    import bridge_pkg::*;

    logic rx_meta;
    logic rx_sync;
    // 0 is idle, 1 to 8 are data bits, 9 is the stop bit
    logic [3:0] bit_idx;
    baud_cnt_t baud_cnt;
    logic baud_zero;

    assign baud_zero = (baud_cnt == '0);

    // line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_idx <= '0;
            baud_cnt <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (bit_idx == 4'd0) begin
                // skip the start bit and land in the middle of bit 0
                if (!rx_sync) begin
                    bit_idx <= 4'd1;
                    baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD + CLKS_PER_BAUD / 2 - 1);
                end
            end else if (baud_zero) begin
                if (bit_idx == 4'd9) begin
                    bit_idx <= '0;
                    valid_o <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                    baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
                end
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (baud_zero && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            data_o <= {rx_sync, data_o[7:1]};
        end
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic               clk,
    input  logic               reset_i,
    input  bridge_pkg::byte_t  data_i,
    input  logic               start_i,
    output logic               done_o,
    output logic               tx_o
);
    import bridge_pkg::*;

    baud_cnt_t baud_cnt;
    // data bits followed by the stop bit
    logic [8:0] frame;
    logic [3:0] bit_idx;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            done_o <= 1'b1;
            tx_o <= 1'b1;
            baud_cnt <= '0;
            bit_idx <= '0;
        end else if (start_i && done_o) begin
            // start bit
            baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
            bit_idx <= '0;
            done_o <= 1'b0;
            tx_o <= 1'b0;
        end else if (!done_o) begin
            baud_cnt <= baud_cnt - 1'b1;
            // done rises on the last stop-bit cycle so a waiting byte follows at once
            if (baud_cnt == baud_cnt_t'(1) && bit_idx == 4'd9) begin
                done_o <= 1'b1;
            end
            if (baud_cnt == '0) begin
                baud_cnt <= baud_cnt_t'(CLKS_PER_BAUD - 1);
                tx_o <= frame[bit_idx];
                bit_idx <= bit_idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i && done_o) begin
            frame <= {1'b1, data_i};
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass message
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_top -o tb_top_sim \
    && ./obj_dir/tb_top_sim | tee /dev/stderr | grep -q '\*\*\* PASSED \*\*\*' \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

/* sim.f */
common/bridge_pkg.sv
common/capture_pkg.sv
common/bus_if.sv
logic/uart_rx.sv
logic/uart_tx.sv
bridge/command_parser.sv
bridge/response_formatter.sv
analyzer/analyzer_regs.sv
analyzer/capture_ctrl.sv
logic/la_top.sv
testbench/tb_top.sv

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import bridge_pkg::*;
    import capture_pkg::*;

    // cycles to wait for a start bit, longer than a whole command
    localparam int START_TIMEOUT = 3000;
    localparam int MAX_POLLS = 20;
    localparam int QUIET_CYCLES = 2500;

    logic clk;
    logic reset_i;
    logic rx_i;
    logic tx_o;
    sample_t probe_i;

    integer seed = 33;
    string hex_digits = "0123456789ABCDEF";

    la_top dut_i (
        .clk     (clk),
        .reset_i (reset_i),
        .rx_i    (rx_i),
        .tx_o    (tx_o),
        .probe_i (probe_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
        else fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    endtask

    // one 8N1 frame, lsb first
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        int k;
        frame = {1'b1, b, 1'b0};
        for (k = 0; k < 10; k++) begin
            @(posedge clk);
            rx_i <= frame[k];
            repeat (CLKS_PER_BAUD - 1) @(posedge clk);
        end
    endtask

    task automatic send_text(input string s);
        int k;
        for (k = 0; k < s.len(); k++) begin
            send_byte(byte_t'(s[k]));
        end
    endtask

    task automatic send_hex4(input word_t w);
        int k;
        for (k = 3; k >= 0; k--) begin
            send_byte(byte_t'(hex_digits[w[4*k +: 4]]));
        end
    endtask

    task automatic write_reg(input word_t addr, input word_t data, input byte_t term);
        send_byte(CHAR_WRITE);
        send_hex4(addr);
        send_hex4(data);
        send_byte(term);
    endtask

    // samples tx_o at bit centers on the falling clock edge
    task automatic receive_byte(input string name, output byte_t b);
        int waited;
        int bit_n;
        waited = 0;
        @(negedge clk);
        while (tx_o !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (tx_o === 1'b0)
        else fail_run($sformatf("%s: no start bit on tx_o within %0d cycles", name, waited));
        repeat (CLKS_PER_BAUD / 2) @(negedge clk);
        assert (tx_o === 1'b0)
        else fail_run($sformatf("%s: start bit on tx_o ended too early", name));
        for (bit_n = 0; bit_n < 8; bit_n++) begin
            repeat (CLKS_PER_BAUD) @(negedge clk);
            b[bit_n] = tx_o;
        end
        repeat (CLKS_PER_BAUD) @(negedge clk);
        assert (tx_o === 1'b1)
        else fail_run($sformatf("%s: stop bit missing on tx_o", name));
    endtask

    task automatic decode_digit(input string name, input byte_t c, output logic [3:0] n);
        int k;
        logic found;
        found = 1'b0;
        n = '0;
        for (k = 0; k < 16; k++) begin
            if (byte_t'(hex_digits[k]) == c) begin
                n = 4'(k);
                found = 1'b1;
            end
        end
        assert (found)
        else fail_run($sformatf("%s: response byte %h is not an uppercase hex digit", name, c));
    endtask

    // the receiver runs alongside the command so the first start edge is never missed
    task automatic read_reg(input string name, input word_t addr, output word_t value);
        byte_t resp [7];
        logic [3:0] n;
        int k;
        fork
            begin
                send_byte(CHAR_READ);
                send_hex4(addr);
                send_byte(CHAR_CR);
            end
            begin
                for (int j = 0; j < 7; j++) begin
                    receive_byte(name, resp[j]);
                end
            end
        join
        check_eq({name, "_header"}, word_t'(CHAR_DATA), word_t'(resp[0]));
        value = '0;
        for (k = 1; k <= 4; k++) begin
            decode_digit(name, resp[k], n);
            value = {value[11:0], n};
        end
        check_eq({name, "_cr"}, word_t'(CHAR_CR), word_t'(resp[5]));
        check_eq({name, "_lf"}, word_t'(CHAR_LF), word_t'(resp[6]));
    endtask

    task automatic expect_read(input string name, input word_t addr, input word_t expected);
        word_t value;
        read_reg(name, addr, value);
        check_eq(name, expected, value);
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        int k;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            assert (tx_o === 1'b1)
            else fail_run($sformatf("%s: unexpected activity on tx_o", name));
        end
    endtask

    // want_equal low means wait until the state differs from target
    task automatic poll_state(input string name, input word_t target, input bit want_equal);
        word_t value;
        int polls;
        logic done;
        polls = 0;
        done = 1'b0;
        while (!done && polls < MAX_POLLS) begin
            read_reg(name, REG_STATE, value);
            done = want_equal ? (value == target) : (value != target);
            polls++;
        end
        assert (done)
        else fail_run($sformatf("%s: capture state stuck after %0d polls, last %h",
                                name, polls, value));
    endtask

    initial begin
        word_t rp;
        word_t value;
        word_t addr;
        sample_t arg;
        logic [31:0] rnd;
        int low_run;
        int high_run;
        int i;

        rx_i = 1'b1;
        probe_i = '0;
        reset_i = 1'b1;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        // idle line, then one exact response
        expect_quiet("reset_idle", 200);
        expect_read("reset_read", REG_STATE, 16'h0000);
        expect_quiet("single_response", QUIET_CYCLES);

        // write and readback
        write_reg(REG_TRIG_LOC, 16'h002A, CHAR_LF);
        expect_read("trig_loc_readback", REG_TRIG_LOC, 16'h002A);
        write_reg(REG_STATE, 16'h0007, CHAR_CR);
        expect_read("state_read_only", REG_STATE, 16'h0000);
        expect_read("unmapped_read", 16'h0100, 16'h0000);

        // old value differs from every malformed payload below
        write_reg(REG_TRIG_LOC, 16'h0013, CHAR_CR);

        // malformed commands are dropped silently
        send_text("W0003002a");
        send_byte(CHAR_CR);
        expect_quiet("lowercase_hex", QUIET_CYCLES);
        send_text("W00030055");
        send_byte(8'h2E);
        expect_quiet("bad_terminator", QUIET_CYCLES);
        send_text("RZ003");
        send_byte(CHAR_CR);
        expect_quiet("non_hex_read", QUIET_CYCLES);
        expect_read("trig_loc_kept", REG_TRIG_LOC, 16'h0013);

        // capture with an EQ trigger
        @(posedge clk);
        probe_i <= 8'h11;
        write_reg(REG_TRIG_OP, word_t'(EQ), CHAR_CR);
        write_reg(REG_TRIG_ARG, 16'h0077, CHAR_CR);
        write_reg(REG_TRIG_LOC, 16'h0008, CHAR_CR);
        write_reg(REG_START, 16'h0001, CHAR_CR);
        poll_state("arm_eq", word_t'(IN_POSITION), 1'b1);
        @(posedge clk);
        probe_i <= 8'h77;
        poll_state("capture_eq", word_t'(CAPTURED), 1'b1);

        // walk the ring from the oldest sample
        read_reg("read_ptr", REG_READ_PTR, rp);
        low_run = 0;
        high_run = 0;
        for (i = 0; i < SAMPLE_DEPTH; i++) begin
            addr = SAMPLE_BASE + word_t'((int'(rp) + i) % SAMPLE_DEPTH);
            read_reg("sample", addr, value);
            assert (value == 16'h0011 || value == 16'h0077)
            else fail_run($sformatf("Fail sample_value: expected 0011 or 0077, actual %h", value));
            if (value == 16'h0077) begin
                high_run++;
            end else begin
                assert (high_run == 0)
                else fail_run("sample order: a pre-trigger sample follows a triggered one");
                low_run++;
            end
        end
        assert (low_run >= 8)
        else fail_run($sformatf("Fail pre_trigger_run: expected at least 8, actual %0d", low_run));
        assert (high_run > 0)
        else fail_run("Fail post_trigger_run: expected at least 1, actual 0");

        // stop, then restart
        write_reg(REG_STOP, 16'h0001, CHAR_CR);
        expect_read("stopped", REG_STATE, 16'h0000);
        write_reg(REG_START, 16'h0000, CHAR_CR);
        write_reg(REG_START, 16'h0001, CHAR_CR);
        poll_state("restart", 16'h0000, 1'b0);

        // GT trigger on random values
        rnd = $random(seed);
        arg = rnd[7:0];
        if (arg == 8'hFF) begin
            arg = 8'hFE;
        end
        rnd = $random(seed);
        @(posedge clk);
        probe_i <= sample_t'(rnd % (32'(arg) + 1));
        write_reg(REG_STOP, 16'h0000, CHAR_CR);
        write_reg(REG_STOP, 16'h0001, CHAR_CR);
        expect_read("gt_stopped", REG_STATE, 16'h0000);
        write_reg(REG_TRIG_OP, word_t'(GT), CHAR_CR);
        write_reg(REG_TRIG_ARG, word_t'(arg), CHAR_CR);
        write_reg(REG_START, 16'h0000, CHAR_CR);
        write_reg(REG_START, 16'h0001, CHAR_CR);
        poll_state("arm_gt", word_t'(IN_POSITION), 1'b1);
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            @(posedge clk);
            probe_i <= sample_t'(rnd % (32'(arg) + 1));
            expect_read("gt_holds", REG_STATE, word_t'(IN_POSITION));
        end
        rnd = $random(seed);
        @(posedge clk);
        probe_i <= arg + 8'd1 + sample_t'(rnd % (32'd255 - 32'(arg)));
        poll_state("capture_gt", word_t'(CAPTURED), 1'b1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
